// File: all.f
common/mesh_pkg.sv
hdl/mesh_pipe.sv
mesh_node/node_alu.sv
mesh_node/mesh_node.sv
hdl/mesh_node_line.sv
dv/tb_clock.sv
dv/mesh_node_line_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the mesh line testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f all.f --top-module mesh_node_line_tb -o sim_mesh_line

status=0
output=$(./obj_dir/sim_mesh_line 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// File: dv/mesh_node_line_tb.sv
/* Testbench for the mesh line with default parameters. Stops at the first mismatch.
   Opcodes and A operands change only while the line is empty. */
`timescale 1ns/10ps

module mesh_node_line_tb
    import mesh_pkg::*;
;

    localparam int WORD_WIDTH      = DEFAULT_WORD_WIDTH;
    localparam int NODE_COUNT      = DEFAULT_NODE_COUNT;
    localparam int EDGE_PIPE_DEPTH = DEFAULT_EDGE_PIPE_DEPTH;
    localparam int NODE_PIPE_DEPTH = DEFAULT_NODE_PIPE_DEPTH;
    localparam int CFG_NODE_WIDTH  = $clog2(NODE_COUNT);
    localparam int LINE_LATENCY    = 2 * EDGE_PIPE_DEPTH + NODE_COUNT
                                     + (NODE_COUNT - 1) * NODE_PIPE_DEPTH;
    localparam int TIMEOUT_CYCLES  = 2000;
    localparam int HIST_LEN        = TIMEOUT_CYCLES + 8;

    logic                             clock;
    logic                             rst;
    logic                             b_in_valid;
    logic [WORD_WIDTH-1:0]            b_in;
    logic                             b_out_valid;
    logic [WORD_WIDTH-1:0]            b_out;
    logic [NODE_COUNT*WORD_WIDTH-1:0] a_in;
    logic [NODE_COUNT*WORD_WIDTH-1:0] a_out;
    logic [NODE_COUNT-1:0]            a_out_valid;
    logic                             cfg_wren;
    logic [CFG_NODE_WIDTH-1:0]        cfg_node;
    mesh_opcode_t                     cfg_opcode;

    // Model of the configuration, kept by the stimulus
    mesh_opcode_t                     model_op [NODE_COUNT];
    logic [WORD_WIDTH-1:0]            model_a  [NODE_COUNT];

    logic [WORD_WIDTH-1:0]            exp_q [$];
    logic [NODE_COUNT*WORD_WIDTH-1:0] side_exp [$];
    int                               side_seen [NODE_COUNT];
    logic                             valid_hist [HIST_LEN];
    int                               neg_count;
    int                               cycle_count;

    tb_clock clocks (
        .clock (clock),
        .rst   (rst)
    );

    mesh_node_line DUT (
        .clock       (clock),
        .rst         (rst),
        .b_in_valid  (b_in_valid),
        .b_in        (b_in),
        .b_out_valid (b_out_valid),
        .b_out       (b_out),
        .a_in        (a_in),
        .a_out       (a_out),
        .a_out_valid (a_out_valid),
        .cfg_wren    (cfg_wren),
        .cfg_node    (cfg_node),
        .cfg_opcode  (cfg_opcode)
    );

    // Fold a word through nodes 0 to last_node
    function automatic logic [WORD_WIDTH-1:0] ref_line(input logic [WORD_WIDTH-1:0] word,
                                                        input int last_node);
        logic [WORD_WIDTH-1:0] b;
        logic [WORD_WIDTH-1:0] a;
        b = word;
        for (int k = 0; k <= last_node; k++) begin
            a = model_a[k];
            case (model_op[k])
                OP_ADD:  b = b + a;
                OP_SUB:  b = b - a;
                OP_AND:  b = b & a;
                OP_OR:   b = b | a;
                OP_XOR:  b = b ^ a;
                OP_MIN:  b = (a < b) ? a : b;
                OP_MAX:  b = (a > b) ? a : b;
                default: b = b;
            endcase
        end
        return b;
    endfunction

    function automatic void record_expected(input logic [WORD_WIDTH-1:0] word);
        logic [NODE_COUNT*WORD_WIDTH-1:0] side;
        side = '0;
        for (int k = 0; k < NODE_COUNT; k++) begin
            side[k*WORD_WIDTH +: WORD_WIDTH] = ref_line(word, k);
        end
        exp_q.push_back(ref_line(word, NODE_COUNT - 1));
        side_exp.push_back(side);
    endfunction

    // Input valid as seen delay negedges ago, low before the run started
    function automatic logic past_valid(input int delay);
        if (neg_count - delay < 0) begin
            return 1'b0;
        end
        return valid_hist[neg_count - delay];
    endfunction

    task automatic stop_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic drive_cycle(input logic valid, input logic [WORD_WIDTH-1:0] word);
        @(posedge clock);
        #1;
        b_in_valid = valid;
        b_in       = word;
        if (valid) begin
            record_expected(word);
        end
    endtask

    task automatic write_opcode(input int node, input mesh_opcode_t op);
        @(posedge clock);
        #1;
        cfg_wren       = 1'b1;
        cfg_node       = CFG_NODE_WIDTH'(node);
        cfg_opcode     = op;
        model_op[node] = op;
        @(posedge clock);
        #1;
        cfg_wren = 1'b0;
    endtask

    task automatic set_operand(input int node, input logic [WORD_WIDTH-1:0] value);
        model_a[node]                       = value;
        a_in[node*WORD_WIDTH +: WORD_WIDTH] = value;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clock);
        end
        repeat (3) @(posedge clock);
        #1;
    endtask

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with words still outstanding", cycle_count);
            stop_run();
        end
    end

    always @(negedge clock) begin : compare
        logic [WORD_WIDTH-1:0] expected;
        int                    idx;
        int                    lat;
        neg_count++;
        valid_hist[neg_count] = b_in_valid;
        if (!rst) begin
            assert (b_out_valid == past_valid(LINE_LATENCY)) else begin
                $display("CHECK FAILED b_out_valid expected %h actual %h",
                         past_valid(LINE_LATENCY), b_out_valid);
                stop_run();
            end
            for (int k = 0; k < NODE_COUNT; k++) begin
                lat = EDGE_PIPE_DEPTH + (k + 1) + k * NODE_PIPE_DEPTH;
                assert (a_out_valid[k] == past_valid(lat)) else begin
                    $display("CHECK FAILED a_out_valid[%0d] expected %h actual %h",
                             k, past_valid(lat), a_out_valid[k]);
                    stop_run();
                end
                if (a_out_valid[k]) begin
                    idx = side_seen[k];
                    assert (idx < side_exp.size()) else begin
                        $display("Node %0d showed a result that no input word explains", k);
                        stop_run();
                    end
                    expected = side_exp[idx][k*WORD_WIDTH +: WORD_WIDTH];
                    assert (a_out[k*WORD_WIDTH +: WORD_WIDTH] == expected) else begin
                        $display("CHECK FAILED a_out[%0d] expected %h actual %h",
                                 k, expected, a_out[k*WORD_WIDTH +: WORD_WIDTH]);
                        stop_run();
                    end
                    side_seen[k]++;
                end
            end
            if (b_out_valid) begin
                assert (exp_q.size() != 0) else begin
                    $display("A word left the east end while none was expected");
                    stop_run();
                end
                expected = exp_q.pop_front();
                assert (b_out == expected) else begin
                    $display("CHECK FAILED b_out expected %h actual %h", expected, b_out);
                    stop_run();
                end
            end
        end
    end

    initial begin : stimulus
        logic sides_done;
        void'($urandom(32'h0e35_1bbf));
        neg_count   = 0;
        cycle_count = 0;
        b_in_valid  = 1'b0;
        b_in        = '0;
        a_in        = '0;
        cfg_wren    = 1'b0;
        cfg_node    = '0;
        cfg_opcode  = OP_PASS;
        for (int k = 0; k < NODE_COUNT; k++) begin
            model_op[k]  = OP_PASS;
            model_a[k]   = '0;
            side_seen[k] = 0;
        end
        for (int i = 0; i < HIST_LEN; i++) begin
            valid_hist[i] = 1'b0;
        end
        @(negedge rst);

        // Idle line, then one word through all PASS nodes
        repeat (LINE_LATENCY) drive_cycle(1'b0, '0);
        drive_cycle(1'b1, WORD_WIDTH'($urandom));
        drive_cycle(1'b0, '0);
        wait_drain();

        // Random opcodes and operands, back to back burst
        for (int k = 0; k < NODE_COUNT; k++) begin
            set_operand(k, WORD_WIDTH'($urandom));
            write_opcode(k, mesh_opcode_t'(3'($urandom_range(7, 0))));
        end
        repeat (50) drive_cycle(1'b1, WORD_WIDTH'($urandom));
        drive_cycle(1'b0, '0);
        wait_drain();

        // Bubbles in the input valid pattern
        repeat (60) drive_cycle($urandom_range(1, 0) == 1, WORD_WIDTH'($urandom));
        drive_cycle(1'b0, '0);
        wait_drain();

        // Edge operands and the compare opcodes
        set_operand(0, '0);
        set_operand(1, '1);
        set_operand(2, '1);
        set_operand(3, '0);
        write_opcode(0, OP_MAX);
        write_opcode(1, OP_SUB);
        write_opcode(2, OP_MIN);
        write_opcode(3, OP_OR);
        drive_cycle(1'b1, '0);
        drive_cycle(1'b1, '1);
        repeat (40) drive_cycle(1'b1, WORD_WIDTH'($urandom));
        drive_cycle(1'b0, '0);
        wait_drain();

        sides_done = 1'b1;
        for (int k = 0; k < NODE_COUNT; k++) begin
            if (side_seen[k] != side_exp.size()) begin
                sides_done = 1'b0;
            end
        end
        if (exp_q.size() == 0 && sides_done) begin
            $display("test passed");
            $finish;
        end else begin
            $display("Run ended with expected results that never appeared");
            stop_run();
        end
    end

endmodule

// File: dv/tb_clock.sv
/* Testbench clock and reset. Reset is synchronous and active high,
   and it drops 1 ns after the last reset edge. */
`timescale 1ns/10ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 5,
    parameter int RESET_CYCLES   = 4
) (
    output logic clock,
    output logic rst
);

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD_NS) clock = ~clock;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        rst = 1'b0;
    end

endmodule

// File: hdl/mesh_node_line.sv
/* Linear line of nodes joined by valid/data pipes, west to east on B, A broadside.
   No back-pressure. Configure opcodes only while the line is empty. */
`timescale 1ns/10ps

module mesh_node_line
    import mesh_pkg::*;
#(
    parameter int WORD_WIDTH      = DEFAULT_WORD_WIDTH,
    parameter int NODE_COUNT      = DEFAULT_NODE_COUNT,
    parameter int EDGE_PIPE_DEPTH = DEFAULT_EDGE_PIPE_DEPTH,
    parameter int NODE_PIPE_DEPTH = DEFAULT_NODE_PIPE_DEPTH,
    localparam int CFG_NODE_WIDTH = (NODE_COUNT > 1) ? $clog2(NODE_COUNT) : 1
) (
    input  logic                             clock,
    input  logic                             rst,

    input  logic                             b_in_valid,
    input  logic [WORD_WIDTH-1:0]            b_in,
    output logic                             b_out_valid,
    output logic [WORD_WIDTH-1:0]            b_out,

    input  logic [NODE_COUNT*WORD_WIDTH-1:0] a_in,
    output logic [NODE_COUNT*WORD_WIDTH-1:0] a_out,
    output logic [NODE_COUNT-1:0]            a_out_valid,

    input  logic                             cfg_wren,
    input  logic [CFG_NODE_WIDTH-1:0]        cfg_node,
    input  mesh_opcode_t                     cfg_opcode
);

    logic [NODE_COUNT-1:0] node_cfg_wren;
    logic [NODE_COUNT-1:0] node_in_valid;
    logic [WORD_WIDTH-1:0] node_in_word  [NODE_COUNT];
    logic [NODE_COUNT-1:0] node_out_valid;
    logic [WORD_WIDTH-1:0] node_out_word [NODE_COUNT];

    // One write enable per node
    always_comb begin
        for (int k = 0; k < NODE_COUNT; k++) begin
            node_cfg_wren[k] = cfg_wren && (cfg_node == CFG_NODE_WIDTH'(k));
        end
    end

    mesh_pipe #(
        .WIDTH (WORD_WIDTH),
        .DEPTH (EDGE_PIPE_DEPTH)
    ) west_pipe (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (b_in_valid),
        .in_data   (b_in),
        .out_valid (node_in_valid[0]),
        .out_data  (node_in_word[0])
    );

    for (genvar k = 0; k < NODE_COUNT; k++) begin : g_node
        mesh_node #(
            .WORD_WIDTH (WORD_WIDTH)
        ) node (
            .clock      (clock),
            .rst        (rst),
            .cfg_wren   (node_cfg_wren[k]),
            .cfg_opcode (cfg_opcode),
            .a_operand  (a_in[k*WORD_WIDTH +: WORD_WIDTH]),
            .in_valid   (node_in_valid[k]),
            .in_word    (node_in_word[k]),
            .out_valid  (node_out_valid[k]),
            .out_word   (node_out_word[k])
        );

        // Broadside results leave without extra stages
        assign a_out[k*WORD_WIDTH +: WORD_WIDTH] = node_out_word[k];
        assign a_out_valid[k]                    = node_out_valid[k];
    end

    // Nearest-neighbour links between nodes
    for (genvar k = 0; k < NODE_COUNT - 1; k++) begin : g_link
        mesh_pipe #(
            .WIDTH (WORD_WIDTH),
            .DEPTH (NODE_PIPE_DEPTH)
        ) link_pipe (
            .clock     (clock),
            .rst       (rst),
            .in_valid  (node_out_valid[k]),
            .in_data   (node_out_word[k]),
            .out_valid (node_in_valid[k+1]),
            .out_data  (node_in_word[k+1])
        );
    end

    mesh_pipe #(
        .WIDTH (WORD_WIDTH),
        .DEPTH (EDGE_PIPE_DEPTH)
    ) east_pipe (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (node_out_valid[NODE_COUNT-1]),
        .in_data   (node_out_word[NODE_COUNT-1]),
        .out_valid (b_out_valid),
        .out_data  (b_out)
    );

endmodule

// File: mesh_node/mesh_node.sv
/* One node of the line, a single registered stage behind the ALU.
   The opcode should only be written while no word is in flight. */
`timescale 1ns/10ps

module mesh_node
    import mesh_pkg::*;
#(
    parameter int WORD_WIDTH = 16
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  cfg_wren,
    input  mesh_opcode_t          cfg_opcode,
    input  logic [WORD_WIDTH-1:0] a_operand,
    input  logic                  in_valid,
    input  logic [WORD_WIDTH-1:0] in_word,
    output logic                  out_valid,
    output logic [WORD_WIDTH-1:0] out_word
);

    mesh_opcode_t          opcode_q;
    logic [WORD_WIDTH-1:0] alu_result;
    logic                  valid_q;
    logic [WORD_WIDTH-1:0] word_q;

    // Configured operation, PASS until written
    always_ff @(posedge clock) begin
        if (rst) begin
            opcode_q <= OP_PASS;
        end else if (cfg_wren) begin
            opcode_q <= cfg_opcode;
        end
    end

    node_alu #(
        .WORD_WIDTH (WORD_WIDTH)
    ) alu (
        .opcode (opcode_q),
        .b_word (in_word),
        .a_word (a_operand),
        .result (alu_result)
    );

    always_ff @(posedge clock) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // The A operand is taken only with a valid word, so the
    // broadside result holds steady across bubbles
    always_ff @(posedge clock) begin
        if (in_valid) begin
            word_q <= alu_result;
        end
    end

    assign out_valid = valid_q;
    assign out_word  = word_q;

endmodule

// File: mesh_node/node_alu.sv
/* Combinational node operation. ADD and SUB wrap, SUB gives b minus a,
   MIN and MAX compare unsigned. */
`timescale 1ns/10ps

module node_alu
    import mesh_pkg::*;
#(
    parameter int WORD_WIDTH = 16
) (
    input  mesh_opcode_t          opcode,
    input  logic [WORD_WIDTH-1:0] b_word,
    input  logic [WORD_WIDTH-1:0] a_word,
    output logic [WORD_WIDTH-1:0] result
);

    always_comb begin
        case (opcode)
            OP_PASS: result = b_word;
            OP_ADD:  result = b_word + a_word;
            OP_SUB:  result = b_word - a_word;
            OP_AND:  result = b_word & a_word;
            OP_OR:   result = b_word | a_word;
            OP_XOR:  result = b_word ^ a_word;
            // Both words are plain vectors here, so the compare is unsigned
            OP_MIN: begin
                if (b_word < a_word) begin
                    result = b_word;
                end else begin
                    result = a_word;
                end
            end
            OP_MAX: begin
                if (b_word > a_word) begin
                    result = b_word;
                end else begin
                    result = a_word;
                end
            end
            default: result = b_word;
        endcase
    end

endmodule

// File: hdl/mesh_pipe.sv
/* Valid and data shift chain, no back-pressure. DEPTH 0 is a plain wire.
   Reset clears the valid bits only, the data stages hold whatever they last shifted. */
`timescale 1ns/10ps

module mesh_pipe #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 1
) (
    input  logic             clock,
    input  logic             rst,
    input  logic             in_valid,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    output logic [WIDTH-1:0] out_data
);

    if (DEPTH == 0) begin : g_wire
        assign out_valid = in_valid;
        assign out_data  = in_data;
    end else begin : g_stages
        logic [DEPTH-1:0] valid_q;
        logic [WIDTH-1:0] data_q [DEPTH];

        always_ff @(posedge clock) begin
            if (rst) begin
                valid_q <= '0;
            end else begin
                valid_q[0] <= in_valid;
                for (int i = 1; i < DEPTH; i++) begin
                    valid_q[i] <= valid_q[i-1];
                end
            end
        end

        // Data moves every cycle so bubbles keep their place
        always_ff @(posedge clock) begin
            data_q[0] <= in_data;
            for (int i = 1; i < DEPTH; i++) begin
                data_q[i] <= data_q[i-1];
            end
        end

        assign out_valid = valid_q[DEPTH-1];
        assign out_data  = data_q[DEPTH-1];
    end

endmodule

// File: common/mesh_pkg.sv
/* Opcodes and default sizes shared by the mesh line.
   MIN and MAX treat words as unsigned. */
package mesh_pkg;

    parameter int OPCODE_WIDTH = 3;

    // Node operation applied to the B word and the node's A operand
    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_PASS = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_AND  = 3'd3,
        OP_OR   = 3'd4,
        OP_XOR  = 3'd5,
        OP_MIN  = 3'd6,
        OP_MAX  = 3'd7
    } mesh_opcode_t;

    // Defaults for the top level and the testbench
    parameter int DEFAULT_WORD_WIDTH      = 16;
    parameter int DEFAULT_NODE_COUNT      = 4;
    parameter int DEFAULT_EDGE_PIPE_DEPTH = 1;
    parameter int DEFAULT_NODE_PIPE_DEPTH = 2;

endpackage
